// ==== axi_line_decoder.f ====
common/line_pkg.sv
rtl/line_arbiter.sv
write_path/write_packer.sv
write_path/write_id_tracker.sv
read_path/read_fetcher.sv
rtl/axi_line_decoder.sv
sim/l2_line_model.sv
sim/tb_axi_line_decoder.sv

// ==== common/line_pkg.sv ====
package line_pkg;

   // Core and L2 byte address width
   localparam int addr_w = 32;

   // Width of the L2 request and response ID
   localparam int id_w = 8;

   // Largest line exponent the datapath is built for (64-byte line)
   localparam int max_line_log2 = 6;

   // A beat of size code n carries 2**n bytes
   typedef logic [2:0] size_t;

   // A burst of length code len carries len + 1 beats
   typedef logic [7:0] len_t;

   function automatic int unsigned beat_bytes(size_t size);
      return 1 << size;
   endfunction

endpackage

// ==== read_path/read_fetcher.sv ====
`timescale 1ns/1ns

module read_fetcher #(
   parameter int LINE_LOG2 = 4
) (
   input  logic                          clk,
   input  logic                          rstn,
   input  logic                          ar_valid,
   output logic                          ar_ready,
   input  logic [line_pkg::addr_w-1:0]   ar_addr,
   input  line_pkg::size_t               ar_size,
   input  line_pkg::len_t                ar_len,
   output logic                          r_valid,
   input  logic                          r_ready,
   output logic [(8<<LINE_LOG2)-1:0]     r_data,
   output logic                          r_last,
   output logic                          rd_valid,
   input  logic                          rd_ready,
   output logic [line_pkg::addr_w-1:0]   rd_addr,
   input  logic                          rsp_valid,
   input  logic                          rsp_write,
   input  logic [(8<<LINE_LOG2)-1:0]     rsp_data
);
   import line_pkg::*;

   localparam int LINE_B = 1 << LINE_LOG2;

   typedef enum logic [1:0] {R_IDLE, R_REQ, R_WAIT, R_DATA} state_t;

   state_t state;
   size_t size;
   len_t beats_left;
   logic [LINE_LOG2-1:0] word;
   logic [LINE_LOG2-1:0] word_max;
   logic [8*LINE_B-1:0] line_q;
   logic beat_fire;
   logic line_done;

   assign ar_ready = (state == R_IDLE);
   assign rd_valid = (state == R_REQ);
   assign r_valid = (state == R_DATA);
   assign r_last = r_valid && (beats_left == '0);
   assign beat_fire = r_valid && r_ready;

   // Index of the last beat-sized word in a line
   assign word_max = LINE_LOG2'(LINE_B / beat_bytes(size) - 1);
   assign line_done = (word == word_max);
   assign r_data = line_q >> {word << size, 3'b000};

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state <= R_IDLE;
      end else begin
         case (state)
            R_IDLE: begin
               if (ar_valid) begin
                  state <= R_REQ;
               end
            end
            R_REQ: begin
               if (rd_ready) begin
                  state <= R_WAIT;
               end
            end
            R_WAIT: begin
               if (rsp_valid && !rsp_write) begin
                  state <= R_DATA;
               end
            end
            default: begin
               if (beat_fire && r_last) begin
                  state <= R_IDLE;
               end else if (beat_fire && line_done) begin
                  state <= R_REQ;
               end
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (ar_valid && ar_ready) begin
         rd_addr <= {ar_addr[addr_w-1:LINE_LOG2], {LINE_LOG2{1'b0}}};
         size <= ar_size;
         beats_left <= ar_len;
         word <= LINE_LOG2'(ar_addr[LINE_LOG2-1:0] >> ar_size);
      end else if (beat_fire) begin
         beats_left <= beats_left - 1'b1;
         if (line_done) begin
            word <= '0;
            rd_addr <= rd_addr + LINE_B;
         end else begin
            word <= word + 1'b1;
         end
      end
      if (state == R_WAIT && rsp_valid && !rsp_write) begin
         line_q <= rsp_data;
      end
   end

   // Only one line read is ever outstanding, so its response finds the FSM waiting
   a_rsp_expected: assert property (@(posedge clk) disable iff (!rstn)
      rsp_valid && !rsp_write |-> state == R_WAIT);

endmodule

// ==== rtl/axi_line_decoder.sv ====
`timescale 1ns/1ns

module axi_line_decoder #(
   parameter int LINE_LOG2 = 4,
   parameter int LOG_MAX_REQUESTS = 2,
   parameter int ID_BASE = 0
) (
   input  logic                          clk,
   input  logic                          rstn,
   input  logic                          aw_valid,
   output logic                          aw_ready,
   input  logic [line_pkg::addr_w-1:0]   aw_addr,
   input  line_pkg::size_t               aw_size,
   input  line_pkg::len_t                aw_len,
   input  logic                          w_valid,
   output logic                          w_ready,
   input  logic [(8<<LINE_LOG2)-1:0]     w_data,
   input  logic [(1<<LINE_LOG2)-1:0]     w_strb,
   input  logic                          w_last,
   output logic                          b_valid,
   input  logic                          b_ready,
   input  logic                          ar_valid,
   output logic                          ar_ready,
   input  logic [line_pkg::addr_w-1:0]   ar_addr,
   input  line_pkg::size_t               ar_size,
   input  line_pkg::len_t                ar_len,
   output logic                          r_valid,
   input  logic                          r_ready,
   output logic [(8<<LINE_LOG2)-1:0]     r_data,
   output logic                          r_last,
   output logic                          l2_req_valid,
   input  logic                          l2_req_ready,
   output logic                          l2_req_write,
   output logic [line_pkg::addr_w-1:0]   l2_req_addr,
   output logic [line_pkg::id_w-1:0]     l2_req_id,
   output logic [(8<<LINE_LOG2)-1:0]     l2_req_data,
   output logic [(1<<LINE_LOG2)-1:0]     l2_req_strb,
   input  logic                          l2_rsp_valid,
   input  logic                          l2_rsp_write,
   input  logic [line_pkg::id_w-1:0]     l2_rsp_id,
   input  logic [(8<<LINE_LOG2)-1:0]     l2_rsp_data
);
   import line_pkg::*;

   logic wr_valid;
   logic wr_ready;
   logic [addr_w-1:0] wr_addr;
   logic [(8<<LINE_LOG2)-1:0] wr_data;
   logic [(1<<LINE_LOG2)-1:0] wr_strb;
   logic [id_w-1:0] slot_id;
   logic issued;
   logic slot_busy;
   logic all_acked;
   logic rd_valid;
   logic rd_ready;
   logic [addr_w-1:0] rd_addr;

   write_packer #(.LINE_LOG2(LINE_LOG2)) u_write_packer (
      .clk(clk), .rstn(rstn),
      .aw_valid(aw_valid), .aw_ready(aw_ready), .aw_addr(aw_addr),
      .aw_size(aw_size), .aw_len(aw_len),
      .w_valid(w_valid), .w_ready(w_ready), .w_data(w_data),
      .w_strb(w_strb), .w_last(w_last),
      .b_valid(b_valid), .b_ready(b_ready),
      .wr_valid(wr_valid), .wr_ready(wr_ready), .wr_addr(wr_addr),
      .wr_data(wr_data), .wr_strb(wr_strb), .issued(issued),
      .slot_busy(slot_busy), .all_acked(all_acked)
   );

   write_id_tracker #(
      .LOG_MAX_REQUESTS(LOG_MAX_REQUESTS),
      .ID_BASE(ID_BASE)
   ) u_write_id_tracker (
      .clk(clk), .rstn(rstn),
      .issued(issued), .burst_done(b_valid && b_ready),
      .rsp_valid(l2_rsp_valid), .rsp_write(l2_rsp_write), .rsp_id(l2_rsp_id),
      .slot_id(slot_id), .slot_busy(slot_busy), .all_acked(all_acked)
   );

   read_fetcher #(.LINE_LOG2(LINE_LOG2)) u_read_fetcher (
      .clk(clk), .rstn(rstn),
      .ar_valid(ar_valid), .ar_ready(ar_ready), .ar_addr(ar_addr),
      .ar_size(ar_size), .ar_len(ar_len),
      .r_valid(r_valid), .r_ready(r_ready), .r_data(r_data), .r_last(r_last),
      .rd_valid(rd_valid), .rd_ready(rd_ready), .rd_addr(rd_addr),
      .rsp_valid(l2_rsp_valid), .rsp_write(l2_rsp_write), .rsp_data(l2_rsp_data)
   );

   // Reads have a single outstanding line, so they always use ID_BASE
   line_arbiter #(.LINE_LOG2(LINE_LOG2)) u_line_arbiter (
      .clk(clk), .rstn(rstn),
      .wr_valid(wr_valid), .wr_ready(wr_ready), .wr_addr(wr_addr),
      .wr_id(slot_id), .wr_data(wr_data), .wr_strb(wr_strb),
      .rd_valid(rd_valid), .rd_ready(rd_ready), .rd_addr(rd_addr),
      .rd_id(id_w'(ID_BASE)),
      .l2_req_valid(l2_req_valid), .l2_req_ready(l2_req_ready),
      .l2_req_write(l2_req_write), .l2_req_addr(l2_req_addr),
      .l2_req_id(l2_req_id), .l2_req_data(l2_req_data), .l2_req_strb(l2_req_strb)
   );

endmodule

// ==== rtl/line_arbiter.sv ====
`timescale 1ns/1ns

module line_arbiter #(
   parameter int LINE_LOG2 = 4
) (
   input  logic                          clk,
   input  logic                          rstn,
   input  logic                          wr_valid,
   output logic                          wr_ready,
   input  logic [line_pkg::addr_w-1:0]   wr_addr,
   input  logic [line_pkg::id_w-1:0]     wr_id,
   input  logic [(8<<LINE_LOG2)-1:0]     wr_data,
   input  logic [(1<<LINE_LOG2)-1:0]     wr_strb,
   input  logic                          rd_valid,
   output logic                          rd_ready,
   input  logic [line_pkg::addr_w-1:0]   rd_addr,
   input  logic [line_pkg::id_w-1:0]     rd_id,
   output logic                          l2_req_valid,
   input  logic                          l2_req_ready,
   output logic                          l2_req_write,
   output logic [line_pkg::addr_w-1:0]   l2_req_addr,
   output logic [line_pkg::id_w-1:0]     l2_req_id,
   output logic [(8<<LINE_LOG2)-1:0]     l2_req_data,
   output logic [(1<<LINE_LOG2)-1:0]     l2_req_strb
);
   import line_pkg::*;

   logic prio_rd;
   logic held;
   logic held_wr;
   logic grant_wr;
   logic grant_rd;

   // A stalled request keeps its grant so the port stays stable until accepted
   assign grant_wr = wr_valid && (held ? held_wr : (!rd_valid || !prio_rd));
   assign grant_rd = rd_valid && !grant_wr;

   assign l2_req_valid = wr_valid || rd_valid;
   assign l2_req_write = grant_wr;
   assign l2_req_addr = grant_wr ? wr_addr : rd_addr;
   assign l2_req_id = grant_wr ? wr_id : rd_id;
   assign l2_req_data = grant_wr ? wr_data : '0;
   assign l2_req_strb = grant_wr ? wr_strb : '0;
   assign wr_ready = grant_wr && l2_req_ready;
   assign rd_ready = grant_rd && l2_req_ready;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         prio_rd <= 1'b0;
         held <= 1'b0;
         held_wr <= 1'b0;
      end else begin
         if (l2_req_valid && l2_req_ready) begin
            prio_rd <= !prio_rd;
         end
         held <= l2_req_valid && !l2_req_ready;
         held_wr <= grant_wr;
      end
   end

   // Both requesters hold their payload, so a stalled port must not move
   a_req_hold: assert property (@(posedge clk) disable iff (!rstn)
      l2_req_valid && !l2_req_ready |=> l2_req_valid && $stable(l2_req_write)
         && $stable(l2_req_addr) && $stable(l2_req_id) && $stable(l2_req_strb));

endmodule

// ==== sim/l2_line_model.sv ====
`timescale 1ns/1ns

module l2_line_model #(
   parameter int LINE_LOG2 = 4,
   parameter int MEM_BYTES = 4096
) (
   input  logic                          clk,
   input  logic                          rstn,
   input  logic                          req_valid,
   output logic                          req_ready,
   input  logic                          req_write,
   input  logic [line_pkg::addr_w-1:0]   req_addr,
   input  logic [line_pkg::id_w-1:0]     req_id,
   input  logic [(8<<LINE_LOG2)-1:0]     req_data,
   input  logic [(1<<LINE_LOG2)-1:0]     req_strb,
   output logic                          rsp_valid,
   output logic                          rsp_write,
   output logic [line_pkg::id_w-1:0]     rsp_id,
   output logic [(8<<LINE_LOG2)-1:0]     rsp_data
);
   import line_pkg::*;

   localparam int LINE_B = 1 << LINE_LOG2;

   logic [7:0] mem [MEM_BYTES];
   logic [id_w:0] pend_tag [$];   // {write, id}
   logic [8*LINE_B-1:0] pend_data [$];
   int unsigned pend_due [$];
   int unsigned cycle = 0;

   initial begin
      for (int a = 0; a < MEM_BYTES; a++) begin
         mem[a] = 8'(a * 7) ^ 8'(a >> 8);
      end
      req_ready = 1'b0;
      rsp_valid = 1'b0;
      rsp_write = 1'b0;
      rsp_id = '0;
      rsp_data = '0;
   end

   // Writes land in memory on acceptance and reads capture the line there too
   always @(posedge clk) begin
      int unsigned base;
      logic [8*LINE_B-1:0] line;
      base = req_addr % MEM_BYTES;
      line = '0;
      if (rstn && req_valid && req_ready) begin
         for (int b = 0; b < LINE_B; b++) begin
            if (req_write && req_strb[b]) begin
               mem[base + b] = req_data[8*b +: 8];
            end
            line[8*b +: 8] = mem[base + b];
         end
         pend_tag.push_back({req_write, req_id});
         pend_data.push_back(line);
         pend_due.push_back(cycle + 1 + $urandom % 8);
      end
      cycle++;
   end

   // Responses leave in order, one per cycle, once their delay has run out
   always @(negedge clk) begin
      req_ready = ($urandom % 4) != 0;
      rsp_valid = 1'b0;
      if (pend_due.size() > 0 && pend_due[0] <= cycle) begin
         rsp_valid = 1'b1;
         {rsp_write, rsp_id} = pend_tag.pop_front();
         rsp_data = pend_data.pop_front();
         void'(pend_due.pop_front());
      end
   end

endmodule

// ==== sim/tb_axi_line_decoder.sv ====
`timescale 1ns/1ns

module tb_axi_line_decoder;
   import line_pkg::*;

   localparam int LINE_LOG2 = 4;
   localparam int LOG_MAX_REQUESTS = 2;
   localparam int ID_BASE = 0;
   localparam int LINE_B = 1 << LINE_LOG2;
   localparam int SLOTS = 1 << LOG_MAX_REQUESTS;
   localparam int MEM_BYTES = 4096;
   localparam int BURSTS = 32;
   localparam int TIMEOUT_CYCLES = BURSTS * 256 * 40 + 1000;

   logic clk;
   logic rstn;
   logic aw_valid;
   logic aw_ready;
   logic [addr_w-1:0] aw_addr;
   size_t aw_size;
   len_t aw_len;
   logic w_valid;
   logic w_ready;
   logic [8*LINE_B-1:0] w_data;
   logic [LINE_B-1:0] w_strb;
   logic w_last;
   logic b_valid;
   logic b_ready;
   logic ar_valid;
   logic ar_ready;
   logic [addr_w-1:0] ar_addr;
   size_t ar_size;
   len_t ar_len;
   logic r_valid;
   logic r_ready;
   logic [8*LINE_B-1:0] r_data;
   logic r_last;
   logic l2_req_valid;
   logic l2_req_ready;
   logic l2_req_write;
   logic [addr_w-1:0] l2_req_addr;
   logic [id_w-1:0] l2_req_id;
   logic [8*LINE_B-1:0] l2_req_data;
   logic [LINE_B-1:0] l2_req_strb;
   logic l2_rsp_valid;
   logic l2_rsp_write;
   logic [id_w-1:0] l2_rsp_id;
   logic [8*LINE_B-1:0] l2_rsp_data;

   logic [7:0] shadow [MEM_BYTES];
   logic [addr_w-1:0] exp_addr_q [$];
   logic [LINE_B-1:0] exp_strb_q [$];
   logic [addr_w-1:0] exp_wr_addr;
   logic [LINE_B-1:0] exp_wr_strb;
   int exp_wr_pending = 0;
   logic [SLOTS-1:0] id_busy;
   logic [8*LINE_B-1:0] exp_r_data;
   logic [8*LINE_B-1:0] r_mask;
   logic exp_r_last;
   logic wr_fire;
   int cycles = 0;

   axi_line_decoder #(
      .LINE_LOG2(LINE_LOG2),
      .LOG_MAX_REQUESTS(LOG_MAX_REQUESTS),
      .ID_BASE(ID_BASE)
   ) dut (.*);

   l2_line_model #(.LINE_LOG2(LINE_LOG2), .MEM_BYTES(MEM_BYTES)) l2 (
      .clk(clk), .rstn(rstn),
      .req_valid(l2_req_valid), .req_ready(l2_req_ready), .req_write(l2_req_write),
      .req_addr(l2_req_addr), .req_id(l2_req_id), .req_data(l2_req_data),
      .req_strb(l2_req_strb), .rsp_valid(l2_rsp_valid), .rsp_write(l2_rsp_write),
      .rsp_id(l2_rsp_id), .rsp_data(l2_rsp_data)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   task automatic stop_run(input string why);
      $display("%s", why);
      $display("sim failed");
      $fatal(1, "stopped at the first error");
   endtask

   function automatic logic [8*LINE_B-1:0] shadow_beat(int unsigned a, int unsigned nb);
      logic [8*LINE_B-1:0] v;
      v = '0;
      for (int k = 0; k < nb; k++) begin
         v[8*k +: 8] = shadow[(a + k) % MEM_BYTES];
      end
      return v;
   endfunction

   task automatic check_memory();
      for (int a = 0; a < MEM_BYTES; a++) begin
         assert (l2.mem[a] == shadow[a])
            else stop_run($sformatf("MISMATCH at %0t: L2 byte %0h holds %0h, expected %0h",
               $time, a, l2.mem[a], shadow[a]));
      end
   endtask

   // Expected line writes are the lines the burst touches, each with its own lanes
   task automatic write_burst(input int unsigned start, input int unsigned size,
                              input int unsigned len);
      int unsigned nb;
      int unsigned a;
      logic [8*LINE_B-1:0] beat [256];
      logic [LINE_B-1:0] strb;
      bit done;
      nb = 1 << size;
      a = start & ~(nb - 1);
      strb = '0;
      for (int i = 0; i <= len; i++) begin
         beat[i] = '0;
         for (int k = 0; k < nb; k++) begin
            beat[i][8*k +: 8] = 8'($urandom);
            shadow[(a + i * nb + k) % MEM_BYTES] = beat[i][8*k +: 8];
         end
         strb |= ({LINE_B{1'b1}} >> (LINE_B - nb)) << ((a + i * nb) % LINE_B);
         if ((a + (i + 1) * nb) % LINE_B == 0 || i == len) begin
            exp_addr_q.push_back(addr_w'((a + i * nb) & ~(LINE_B - 1)));
            exp_strb_q.push_back(strb);
            strb = '0;
         end
      end
      @(negedge clk);
      aw_valid = 1'b1;
      aw_addr = addr_w'(a);
      aw_size = size_t'(size);
      aw_len = len_t'(len);
      do @(posedge clk); while (!aw_ready);
      @(negedge clk);
      aw_valid = 1'b0;
      for (int i = 0; i <= len; i++) begin
         w_valid = 1'b1;
         w_data = beat[i];
         w_strb = {LINE_B{1'b1}} >> (LINE_B - nb);
         w_last = (i == len);
         do @(posedge clk); while (!w_ready);
         @(negedge clk);
      end
      w_valid = 1'b0;
      w_last = 1'b0;
      done = 1'b0;
      while (!done) begin
         b_ready = ($urandom % 2) == 1;
         @(posedge clk);
         done = b_valid && b_ready;
         @(negedge clk);
      end
      b_ready = 1'b0;
   endtask

   task automatic read_burst(input int unsigned start, input int unsigned size,
                             input int unsigned len);
      int unsigned nb;
      int unsigned a;
      int unsigned n;
      nb = 1 << size;
      a = start & ~(nb - 1);
      n = 0;
      r_mask = {8*LINE_B{1'b1}} >> (8 * (LINE_B - nb));
      exp_r_data = shadow_beat(a, nb);
      exp_r_last = (len == 0);
      @(negedge clk);
      ar_valid = 1'b1;
      ar_addr = addr_w'(a);
      ar_size = size_t'(size);
      ar_len = len_t'(len);
      do @(posedge clk); while (!ar_ready);
      @(negedge clk);
      ar_valid = 1'b0;
      while (n <= len) begin
         r_ready = ($urandom % 4) != 0;
         @(posedge clk);
         if (r_valid && r_ready) begin
            n++;
            exp_r_data = shadow_beat(a + n * nb, nb);
            exp_r_last = (n == len);
         end
         @(negedge clk);
      end
      r_ready = 1'b0;
   endtask

   assign wr_fire = l2_req_valid && l2_req_ready && l2_req_write;

   // Mirror of the outstanding write IDs and the head of the expected line writes
   always @(posedge clk) begin
      if (!rstn) begin
         id_busy = '0;
      end else begin
         if (l2_rsp_valid && l2_rsp_write) begin
            id_busy[LOG_MAX_REQUESTS'(l2_rsp_id - id_w'(ID_BASE))] = 1'b0;
         end
         if (wr_fire) begin
            id_busy[LOG_MAX_REQUESTS'(l2_req_id - id_w'(ID_BASE))] = 1'b1;
         end
         if (wr_fire && exp_addr_q.size() > 0) begin
            void'(exp_addr_q.pop_front());
            void'(exp_strb_q.pop_front());
         end
      end
      if (exp_addr_q.size() > 0) begin
         exp_wr_addr = exp_addr_q[0];
         exp_wr_strb = exp_strb_q[0];
      end
      exp_wr_pending = exp_addr_q.size();
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles > TIMEOUT_CYCLES) begin
         stop_run("Timeout: the bursts did not finish within the cycle limit");
      end
   end

   a_line_base: assert property (@(posedge clk) disable iff (!rstn)
      l2_req_valid |-> l2_req_addr[LINE_LOG2-1:0] == '0)
      else stop_run($sformatf("MISMATCH at %0t: L2 request address not line aligned", $time));

   a_wr_line: assert property (@(posedge clk) disable iff (!rstn)
      wr_fire |-> exp_wr_pending > 0 && l2_req_addr == exp_wr_addr
         && l2_req_strb == exp_wr_strb)
      else stop_run($sformatf("MISMATCH at %0t: unexpected line write address or strobe",
         $time));

   a_wr_id: assert property (@(posedge clk) disable iff (!rstn)
      wr_fire |-> id_w'(l2_req_id - id_w'(ID_BASE)) < SLOTS
         && !id_busy[LOG_MAX_REQUESTS'(l2_req_id - id_w'(ID_BASE))])
      else stop_run($sformatf("MISMATCH at %0t: write ID out of range or still in use",
         $time));

   a_b_acked: assert property (@(posedge clk) disable iff (!rstn)
      b_valid |-> id_busy == '0 && exp_wr_pending == 0)
      else stop_run($sformatf("MISMATCH at %0t: write response before all line acks",
         $time));

   a_r_data: assert property (@(posedge clk) disable iff (!rstn)
      r_valid && r_ready |-> (r_data & r_mask) == exp_r_data)
      else stop_run($sformatf("MISMATCH at %0t: read beat data differs from memory", $time));

   a_r_last: assert property (@(posedge clk) disable iff (!rstn)
      r_valid && r_ready |-> r_last == exp_r_last)
      else stop_run($sformatf("MISMATCH at %0t: r_last on the wrong beat", $time));

   a_req_hold: assert property (@(posedge clk) disable iff (!rstn)
      l2_req_valid && !l2_req_ready |=> l2_req_valid && $stable(l2_req_write)
         && $stable(l2_req_addr) && $stable(l2_req_id) && $stable(l2_req_data)
         && $stable(l2_req_strb))
      else stop_run("The L2 request dropped or changed while the port was stalled");

   a_r_hold: assert property (@(posedge clk) disable iff (!rstn)
      r_valid && !r_ready |=> r_valid && $stable(r_data) && $stable(r_last))
      else stop_run("The read beat dropped or changed while r_ready was low");

   a_b_hold: assert property (@(posedge clk) disable iff (!rstn)
      b_valid && !b_ready |=> b_valid)
      else stop_run("b_valid dropped before b_ready was seen");

   initial begin
      int unsigned size;
      int unsigned nb;
      int unsigned off;
      int unsigned wa;
      int unsigned ws;
      int unsigned wl;
      int unsigned ra;
      int unsigned rs;
      int unsigned rl;
      void'($urandom(2114));
      rstn = 1'b0;
      aw_valid = 1'b0;
      aw_addr = '0;
      aw_size = '0;
      aw_len = '0;
      w_valid = 1'b0;
      w_data = '0;
      w_strb = '0;
      w_last = 1'b0;
      b_ready = 1'b0;
      ar_valid = 1'b0;
      ar_addr = '0;
      ar_size = '0;
      ar_len = '0;
      r_ready = 1'b0;
      for (int a = 0; a < MEM_BYTES; a++) begin
         shadow[a] = 8'(a * 7) ^ 8'(a >> 8);
      end
      repeat (16) @(negedge clk);
      rstn = 1'b1;

      // Narrow writes that stay inside one line
      for (int i = 0; i < 8; i++) begin
         size = i % 4;
         nb = 1 << size;
         off = ($urandom % LINE_B) & ~(nb - 1);
         write_burst(($urandom % 128) * LINE_B + off, size, $urandom % ((LINE_B - off) / nb));
         check_memory();
      end
      for (int i = 0; i < 4; i++) begin
         write_burst($urandom % 2048, $urandom % 3, 16 + $urandom % 48);
      end
      for (int i = 0; i < 12; i++) begin
         read_burst($urandom % 2048, $urandom % (LINE_LOG2 + 1), $urandom % 32);
      end

      // Reads from the low kilobyte while writes go to the upper half
      for (int i = 0; i < 4; i++) begin
         wa = 2048 + $urandom % 1024;
         ws = $urandom % 3;
         wl = $urandom % 64;
         ra = $urandom % 1024;
         rs = $urandom % 4;
         rl = $urandom % 32;
         fork
            write_burst(wa, ws, wl);
            read_burst(ra, rs, rl);
         join
      end
      check_memory();
      $display("sim passed");
      $finish;
   end

endmodule

// ==== write_path/write_id_tracker.sv ====
`timescale 1ns/1ns

module write_id_tracker #(
   parameter int LOG_MAX_REQUESTS = 2,
   parameter int ID_BASE = 0
) (
   input  logic                          clk,
   input  logic                          rstn,
   input  logic                          issued,
   input  logic                          burst_done,
   input  logic                          rsp_valid,
   input  logic                          rsp_write,
   input  logic [line_pkg::id_w-1:0]     rsp_id,
   output logic [line_pkg::id_w-1:0]     slot_id,
   output logic                          slot_busy,
   output logic                          all_acked
);
   import line_pkg::*;

   localparam int SLOTS = 1 << LOG_MAX_REQUESTS;

   logic [LOG_MAX_REQUESTS-1:0] slot;
   logic [LOG_MAX_REQUESTS-1:0] rsp_slot;
   logic [SLOTS-1:0] in_use;
   logic wr_rsp;

   assign slot_id = id_w'(ID_BASE) + id_w'(slot);
   assign rsp_slot = LOG_MAX_REQUESTS'(rsp_id - id_w'(ID_BASE));
   assign wr_rsp = rsp_valid && rsp_write;
   assign slot_busy = in_use[slot];
   assign all_acked = (in_use == '0);

   always_ff @(posedge clk) begin
      if (!rstn) begin
         slot <= '0;
         in_use <= '0;
      end else begin
         if (wr_rsp) begin
            in_use[rsp_slot] <= 1'b0;
         end
         if (issued) begin
            in_use[slot] <= 1'b1;
         end
         // Slots wrap within a burst and the busy flag stalls their reuse
         if (burst_done) begin
            slot <= '0;
         end else if (issued) begin
            slot <= slot + 1'b1;
         end
      end
   end

   a_rsp_known: assert property (@(posedge clk) disable iff (!rstn)
      wr_rsp |-> in_use[rsp_slot]);

endmodule

// ==== write_path/write_packer.sv ====
`timescale 1ns/1ns

module write_packer #(
   parameter int LINE_LOG2 = 4
) (
   input  logic                          clk,
   input  logic                          rstn,
   input  logic                          aw_valid,
   output logic                          aw_ready,
   input  logic [line_pkg::addr_w-1:0]   aw_addr,
   input  line_pkg::size_t               aw_size,
   input  line_pkg::len_t                aw_len,
   input  logic                          w_valid,
   output logic                          w_ready,
   input  logic [(8<<LINE_LOG2)-1:0]     w_data,
   input  logic [(1<<LINE_LOG2)-1:0]     w_strb,
   input  logic                          w_last,
   output logic                          b_valid,
   input  logic                          b_ready,
   output logic                          wr_valid,
   input  logic                          wr_ready,
   output logic [line_pkg::addr_w-1:0]   wr_addr,
   output logic [(8<<LINE_LOG2)-1:0]     wr_data,
   output logic [(1<<LINE_LOG2)-1:0]     wr_strb,
   output logic                          issued,
   input  logic                          slot_busy,
   input  logic                          all_acked
);
   import line_pkg::*;

   localparam int LINE_B = 1 << LINE_LOG2;

   typedef enum logic [1:0] {W_IDLE, W_COLLECT, W_ISSUE, W_WAIT_ACK} state_t;

   state_t state;
   logic [addr_w-1:0] addr;
   logic [addr_w-1:0] next_addr;
   size_t size;
   len_t beats_left;
   logic last_line;
   logic beat_fire;
   logic beat_last;
   logic line_end;
   logic [LINE_LOG2-1:0] lane_off;
   logic [LINE_B-1:0] byte_en;
   logic [LINE_B-1:0] lane_en;
   logic [LINE_B-1:0] lane_strb;
   logic [8*LINE_B-1:0] lane_data;

   assign aw_ready = (state == W_IDLE);
   assign w_ready = (state == W_COLLECT);
   assign wr_valid = (state == W_ISSUE) && !slot_busy;
   assign issued = wr_valid && wr_ready;
   assign b_valid = (state == W_WAIT_ACK) && all_acked;

   assign beat_fire = w_valid && w_ready;
   assign beat_last = (beats_left == '0);
   assign next_addr = addr + beat_bytes(size);
   assign line_end = (next_addr[LINE_LOG2-1:0] == '0);

   // Beat bytes sit low in w_data and move up to their lane in the line
   assign lane_off = addr[LINE_LOG2-1:0];
   always_comb begin
      for (int b = 0; b < LINE_B; b++) begin
         byte_en[b] = (b < beat_bytes(size));
      end
   end
   assign lane_en = byte_en << lane_off;
   assign lane_strb = (w_strb & byte_en) << lane_off;
   assign lane_data = w_data << {lane_off, 3'b000};

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state <= W_IDLE;
      end else begin
         case (state)
            W_IDLE: begin
               if (aw_valid) begin
                  state <= W_COLLECT;
               end
            end
            W_COLLECT: begin
               if (beat_fire && (line_end || beat_last)) begin
                  state <= W_ISSUE;
               end
            end
            W_ISSUE: begin
               if (issued) begin
                  state <= last_line ? W_WAIT_ACK : W_COLLECT;
               end
            end
            default: begin
               if (b_valid && b_ready) begin
                  state <= W_IDLE;
               end
            end
         endcase
      end
   end

   // Start address is aligned down to the beat size so stepping hits line edges
   always_ff @(posedge clk) begin
      if (aw_valid && aw_ready) begin
         addr <= aw_addr & ~(addr_w'(beat_bytes(aw_size)) - 1'b1);
         size <= aw_size;
         beats_left <= aw_len;
      end else if (beat_fire) begin
         addr <= next_addr;
         beats_left <= beats_left - 1'b1;
         last_line <= beat_last;
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         wr_strb <= '0;
      end else if (beat_fire) begin
         wr_strb <= wr_strb | lane_strb;
      end else if (issued) begin
         wr_strb <= '0;
      end
   end

   always_ff @(posedge clk) begin
      if (beat_fire) begin
         for (int b = 0; b < LINE_B; b++) begin
            if (lane_en[b]) begin
               wr_data[8*b +: 8] <= lane_data[8*b +: 8];
            end
         end
         wr_addr <= {addr[addr_w-1:LINE_LOG2], {LINE_LOG2{1'b0}}};
      end else if (issued) begin
         wr_data <= '0;
      end
   end

   a_line_log2: assert property (@(posedge clk) LINE_LOG2 <= max_line_log2);

   // A line write waiting on the L2 keeps its slot free until it is taken
   a_no_issue_busy: assert property (@(posedge clk) disable iff (!rstn)
      wr_valid && !wr_ready |=> !slot_busy);

   // The core's w_last must agree with the beat count taken from aw_len
   a_wlast: assert property (@(posedge clk) disable iff (!rstn)
      beat_fire |-> (w_last == beat_last));

endmodule
